// File: project.f
logic/commit_pkg.sv
logic/execute_commit_reg.sv
logic/commit_stage.sv
logic/trap_unit.sv
logic/branch_history_table.sv
logic/commit_subsystem.sv
sim/commit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the commit subsystem testbench with Verilator and run it.
# The result is read from sim.log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module commit_tb -o commit_sim
./obj_dir/commit_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"

// File: sim/commit_tb.sv
//////////////////////////////////////////////////
// Commit subsystem testbench
// Directed tests for exceptions, priority, interrupt
// return addresses, mret, stall, flush and the BHT.
//////////////////////////////////////////////////
module commit_tb import commit_pkg::*; ();

  // The tests need under 100 cycles after reset, so this limit is generous.
  localparam int MAX_CYCLES = 2000;
  localparam int IDX_W      = $clog2(BHT_ENTRIES_DEFAULT);

  logic  CLK, nRST;
  logic  ex_valid, ex_dren, ex_dwen, ex_mal_addr;
  logic  ex_illegal_insn, ex_invalid_csr, ex_mal_insn;
  logic  ex_breakpoint, ex_ecall, ex_ret, ex_jump, ex_branch;
  logic  ex_branch_taken, ex_prediction;
  word_t ex_pc, ex_mem_addr, ex_jump_addr, ex_br_addr, fetch_pc;
  logic  intr_pending, halt, pc_en;
  logic  trap, mret_taken, redirect, mispredict, predict_taken;
  word_t redirect_pc, mepc, mcause, mtval;

  int cycle_count  = 0;
  int test_errs    = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  // Reference copy of the two-bit predictor counters.
  logic [1:0] model_cnt [BHT_ENTRIES_DEFAULT];

  commit_subsystem dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Advance to just after the next rising edge, where inputs change.
  task automatic step();
    @(posedge CLK);
    #2;
  endtask

  // Put a bubble on the execute side.
  task automatic clear_ex();
    {ex_valid, ex_dren, ex_dwen, ex_mal_addr, ex_illegal_insn, ex_invalid_csr,
     ex_mal_insn, ex_breakpoint, ex_ecall, ex_ret, ex_jump, ex_branch,
     ex_branch_taken, ex_prediction} = '0;
    {ex_pc, ex_mem_addr, ex_jump_addr, ex_br_addr} = '0;
  endtask

  function automatic word_t aligned_word();
    return $urandom() & 32'hffff_fffc;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  // Saturating two-bit counter step.
  function automatic logic [1:0] next_count(input logic [1:0] cnt, input logic taken);
    if (taken) return (cnt == 2'd3) ? cnt : cnt + 2'd1;
    return (cnt == 2'd0) ? cnt : cnt - 2'd1;
  endfunction

  // Expected cause and mtval for the instruction on the ex_ inputs.
  // Causes are listed from highest to lowest priority.
  task automatic model_trap(output word_t cause, output word_t tval, output logic hit);
    logic mal_i;
    mal_i = ex_mal_insn | (ex_jump & (ex_jump_addr[1:0] != 2'b00)) |
            (ex_branch & (ex_br_addr[1:0] != 2'b00));
    hit   = 1'b1;
    cause = '0;
    tval  = '0;
    if (mal_i) tval = ex_pc;
    else if (ex_illegal_insn | ex_invalid_csr) cause = 32'd2;
    else if (ex_breakpoint) cause = 32'd3;
    else if (ex_ecall) cause = 32'd11;
    else if (ex_dren & ex_mal_addr) {cause, tval} = {32'd4, ex_mem_addr};
    else if (ex_dwen & ex_mal_addr) {cause, tval} = {32'd6, ex_mem_addr};
    else hit = 1'b0;
  endtask

  task automatic check_trap(input word_t pc, input word_t cause, input word_t tval);
    check_bit("trap", trap, 1'b1);
    check_bit("redirect", redirect, 1'b1);
    check_bit("mret_taken", mret_taken, 1'b0);
    check_word("redirect_pc", redirect_pc, TRAP_VECTOR_DEFAULT);
    check_word("mepc", mepc, pc);
    check_word("mcause", mcause, cause);
    check_word("mtval", mtval, tval);
  endtask

  // Commit the instruction on the ex_ inputs and check the outcome two cycles on.
  task automatic run_and_check();
    word_t cause, tval, pc;
    logic  hit;
    model_trap(cause, tval, hit);
    pc = ex_pc;
    step();
    clear_ex();
    step();
    if (hit) check_trap(pc, cause, tval);
    else check_bit("trap", trap, 1'b0);
  endtask

  // Runs first, while every counter still holds its reset value.
  task automatic test_branch_predictor();
    word_t            br_pc;
    logic [IDX_W-1:0] idx;
    logic [5:0]       taken_seq;
    logic [5:0]       pred_seq;
    taken_seq = 6'b000111;
    pred_seq  = 6'b011110;
    br_pc     = aligned_word();
    idx       = br_pc[IDX_W+1:2];
    fetch_pc  = br_pc;
    #1;
    check_bit("predict_taken", predict_taken, 1'b0);
    for (int k = 0; k < 6; k++) begin
      clear_ex();
      ex_valid        = 1'b1;
      ex_pc           = aligned_word();
      ex_branch       = 1'b1;
      ex_br_addr      = br_pc;
      ex_branch_taken = taken_seq[k];
      ex_prediction   = pred_seq[k];
      step();
      check_bit("mispredict", mispredict, taken_seq[k] ^ pred_seq[k]);
      clear_ex();
      step();
      model_cnt[idx] = next_count(model_cnt[idx], taken_seq[k]);
      check_bit("mispredict", mispredict, 1'b0);
      check_bit("trap", trap, 1'b0);
      check_bit("predict_taken", predict_taken, model_cnt[idx][1]);
    end
    finish_test("branch predictor");
  endtask

  // One fault per instruction. Misaligned targets and mal_addr are always
  // present but only count when jump, branch, load or store is set.
  task automatic test_single_exceptions();
    string names [9] = '{"jump target", "branch target", "mal_insn flag",
                         "illegal opcode", "invalid csr", "breakpoint", "ecall",
                         "misaligned load", "misaligned store"};
    for (int k = 0; k < 9; k++) begin
      clear_ex();
      ex_valid     = 1'b1;
      ex_pc        = aligned_word();
      ex_mem_addr  = $urandom();
      ex_mal_addr  = 1'b1;
      ex_jump_addr = aligned_word() | 32'd1;
      ex_br_addr   = aligned_word() | 32'd2;
      case (k)
        0: ex_jump = 1'b1;
        1: ex_branch = 1'b1;
        2: ex_mal_insn = 1'b1;
        3: ex_illegal_insn = 1'b1;
        4: ex_invalid_csr = 1'b1;
        5: ex_breakpoint = 1'b1;
        6: ex_ecall = 1'b1;
        7: ex_dren = 1'b1;
        default: ex_dwen = 1'b1;
      endcase
      run_and_check();
      finish_test(names[k]);
    end
  endtask

  task automatic test_priority();
    clear_ex();
    ex_valid        = 1'b1;
    ex_pc           = aligned_word();
    ex_mem_addr     = $urandom();
    ex_illegal_insn = 1'b1;
    ex_dwen         = 1'b1;
    ex_mal_addr     = 1'b1;
    run_and_check();
    ex_valid      = 1'b1;
    ex_pc         = aligned_word();
    ex_mem_addr   = $urandom();
    ex_ecall      = 1'b1;
    ex_breakpoint = 1'b1;
    ex_dren       = 1'b1;
    ex_mal_addr   = 1'b1;
    run_and_check();
    finish_test("priority");
  endtask

  task automatic test_interrupt_epc();
    word_t pc_a, pc_b;
    clear_ex();
    ex_valid = 1'b1;
    ex_pc    = aligned_word();
    pc_a     = ex_pc;
    step();
    // The interrupt arrives while pc_a sits in commit.
    clear_ex();
    intr_pending = 1'b1;
    step();
    intr_pending = 1'b0;
    check_trap(pc_a, 32'h8000_000b, '0);
    ex_valid = 1'b1;
    ex_pc    = aligned_word();
    pc_b     = ex_pc;
    run_and_check();
    // Commit now holds a bubble, so the last valid PC is used.
    intr_pending = 1'b1;
    step();
    intr_pending = 1'b0;
    check_trap(pc_b, 32'h8000_000b, '0);
    halt = 1'b1;
    step();
    halt         = 1'b0;
    intr_pending = 1'b1;
    step();
    intr_pending = 1'b0;
    check_trap('0, 32'h8000_000b, '0);
    finish_test("interrupt epc");
  endtask

  task automatic test_mret();
    word_t trap_pc;
    clear_ex();
    ex_valid = 1'b1;
    ex_pc    = aligned_word();
    ex_ecall = 1'b1;
    trap_pc  = ex_pc;
    run_and_check();
    ex_valid = 1'b1;
    ex_pc    = aligned_word();
    ex_ret   = 1'b1;
    step();
    clear_ex();
    step();
    check_bit("mret_taken", mret_taken, 1'b1);
    check_bit("redirect", redirect, 1'b1);
    check_bit("trap", trap, 1'b0);
    check_word("redirect_pc", redirect_pc, trap_pc);
    check_word("mepc", mepc, trap_pc);
    finish_test("mret");
  endtask

  task automatic test_stall_flush();
    word_t trap_pc, old_mepc;
    old_mepc = mepc;
    clear_ex();
    // A pending interrupt must also wait while the pipeline is stalled.
    pc_en        = 1'b0;
    intr_pending = 1'b1;
    ex_valid     = 1'b1;
    ex_pc        = aligned_word();
    ex_ecall     = 1'b1;
    trap_pc      = ex_pc;
    repeat (4) begin
      step();
      check_bit("trap", trap, 1'b0);
      check_word("mepc", mepc, old_mepc);
    end
    intr_pending = 1'b0;
    pc_en        = 1'b1;
    run_and_check();
    // A second ecall enters while the first one traps and must be squashed.
    ex_valid = 1'b1;
    ex_pc    = aligned_word();
    ex_ecall = 1'b1;
    trap_pc  = ex_pc;
    step();
    ex_pc = aligned_word();
    step();
    clear_ex();
    check_trap(trap_pc, 32'd11, '0);
    step();
    check_bit("trap", trap, 1'b0);
    check_word("mepc", mepc, trap_pc);
    finish_test("stall and flush");
  endtask

  initial begin
    void'($urandom(32'h5db0_fdbe));
    clear_ex();
    intr_pending = 1'b0;
    halt         = 1'b0;
    pc_en        = 1'b1;
    fetch_pc     = '0;
    nRST         = 1'b0;
    for (int i = 0; i < BHT_ENTRIES_DEFAULT; i++) model_cnt[i] = 2'b01;
    repeat (16) @(posedge CLK);
    #2;
    nRST = 1'b1;
    test_branch_predictor();
    test_single_exceptions();
    test_priority();
    test_interrupt_epc();
    test_mret();
    test_stall_flush();
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: logic/commit_subsystem.sv
//////////////////////////////////////////////////
// Commit subsystem
// Connects the commit register, commit stage, trap
// unit and branch history table.
//////////////////////////////////////////////////
module commit_subsystem import commit_pkg::*; #(
  parameter word_t TRAP_VECTOR = TRAP_VECTOR_DEFAULT,
  parameter int    BHT_ENTRIES = BHT_ENTRIES_DEFAULT
) (
  input  logic  CLK, nRST,
  input  logic  ex_valid,
  input  word_t ex_pc, ex_mem_addr,
  input  logic  ex_dren, ex_dwen, ex_mal_addr,
  input  logic  ex_illegal_insn, ex_invalid_csr, ex_mal_insn,
  input  logic  ex_breakpoint, ex_ecall, ex_ret,
  input  logic  ex_jump,
  input  word_t ex_jump_addr,
  input  logic  ex_branch,
  input  word_t ex_br_addr,
  input  logic  ex_branch_taken, ex_prediction,
  input  logic  intr_pending, halt, pc_en,
  input  word_t fetch_pc,
  output logic  trap, mret_taken, redirect,
  output word_t redirect_pc, mepc, mcause, mtval,
  output logic  mispredict,
  output logic  predict_taken
);

  // Instruction as seen by the commit stage.
  logic  c_valid;
  word_t c_pc, c_mem_addr;
  logic  c_dren, c_dwen, c_mal_addr;
  logic  c_illegal_insn, c_invalid_csr, c_mal_insn;
  logic  c_breakpoint, c_ecall, c_ret;
  logic  c_jump;
  word_t c_jump_addr;
  logic  c_branch;
  word_t c_br_addr;
  logic  c_branch_taken, c_prediction;

  // Commit to trap unit strobes and addresses.
  logic  flush, intr_taken, retire;
  logic  mal_insn_req, illegal_req, break_req, ecall_req, ret_req;
  logic  mal_load_req, mal_store_req;
  word_t bad_addr_i, bad_addr_d, epc;

  // Predictor training from commit.
  logic  bht_update, bht_taken;
  word_t bht_addr;

  // mcause leaves the subsystem as a plain CSR word.
  mcause_t mcause_q;

  // All blocks share port names with the wires above.
  execute_commit_reg reg_i (.*);

  commit_stage stage_i (.*);

  trap_unit #(.TRAP_VECTOR(TRAP_VECTOR)) trap_i (.*, .mcause(mcause_q));

  branch_history_table #(.BHT_ENTRIES(BHT_ENTRIES)) bht_i (.*);

  assign mcause = mcause_q.raw;

endmodule

// File: logic/branch_history_table.sv
//////////////////////////////////////////////////
// Branch history table
// Two-bit saturating counters indexed by word PC,
// trained at commit and read by fetch.
//////////////////////////////////////////////////
module branch_history_table import commit_pkg::*; #(
  parameter int BHT_ENTRIES = BHT_ENTRIES_DEFAULT
) (
  input  logic  CLK, nRST,
  input  logic  bht_update,
  input  word_t bht_addr,
  input  logic  bht_taken,
  input  word_t fetch_pc,
  output logic  predict_taken
);

  localparam int IDX_W = $clog2(BHT_ENTRIES);

  logic [1:0]       counters [BHT_ENTRIES];
  logic [IDX_W-1:0] upd_idx;
  logic [IDX_W-1:0] fetch_idx;
  logic [1:0]       upd_cnt;

  // The two low PC bits are always zero for aligned code.
  assign upd_idx   = bht_addr[IDX_W+1:2];
  assign fetch_idx = fetch_pc[IDX_W+1:2];
  assign upd_cnt   = counters[upd_idx];

  // Counter training.
  // Every entry starts weakly not-taken and saturates at 0 and 3.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        counters[i] <= 2'b01;
      end
    end else if (bht_update) begin
      if (bht_taken && (upd_cnt != 2'b11)) begin
        counters[upd_idx] <= upd_cnt + 2'd1;
      end else if (!bht_taken && (upd_cnt != 2'b00)) begin
        counters[upd_idx] <= upd_cnt - 2'd1;
      end
    end
  end

  // Fetch predicts taken when the counter is in the upper half.
  assign predict_taken = counters[fetch_idx][1];

endmodule

// File: logic/trap_unit.sv
//////////////////////////////////////////////////
// Trap unit
// Picks the winning cause, writes mepc, mcause and
// mtval, and redirects fetch on trap entry or mret.
//////////////////////////////////////////////////
module trap_unit import commit_pkg::*; #(
  parameter word_t TRAP_VECTOR = TRAP_VECTOR_DEFAULT
) (
  input  logic    CLK, nRST,
  input  logic    intr_taken,
  input  logic    mal_insn_req, illegal_req, break_req, ecall_req, ret_req,
  input  logic    mal_load_req, mal_store_req,
  input  word_t   bad_addr_i, bad_addr_d, epc,
  output logic    flush, trap, mret_taken, redirect,
  output word_t   redirect_pc, mepc,
  output mcause_t mcause,
  output word_t   mtval
);

  logic    take_trap;
  mcause_t next_cause;
  word_t   next_tval;

  // Any request strobe enters the trap handler.
  assign take_trap = intr_taken | mal_insn_req | illegal_req | break_req |
                     ecall_req | mal_load_req | mal_store_req;

  // Both trap entry and mret squash the instruction behind commit.
  assign flush = take_trap | ret_req;

  // Causes are resolved by priority with the interrupt first.
  // mtval carries the faulting address for misaligned fetch and data only.
  always_comb begin
    next_cause.raw = '0;
    next_tval      = '0;
    if (intr_taken) begin
      next_cause.f.interrupt = 1'b1;
      next_cause.f.code      = CAUSE_EXT_INTR;
    end else if (mal_insn_req) begin
      next_cause.f.code = CAUSE_MAL_INSN;
      next_tval         = bad_addr_i;
    end else if (illegal_req) begin
      next_cause.f.code = CAUSE_ILLEGAL;
    end else if (break_req) begin
      next_cause.f.code = CAUSE_BREAKPOINT;
    end else if (ecall_req) begin
      next_cause.f.code = CAUSE_ECALL_M;
    end else if (mal_load_req) begin
      next_cause.f.code = CAUSE_MAL_LOAD;
      next_tval         = bad_addr_d;
    end else if (mal_store_req) begin
      next_cause.f.code = CAUSE_MAL_STORE;
      next_tval         = bad_addr_d;
    end
  end

  // Trap registers and the one-cycle redirect pulses.
  // An mret that also raised an exception traps instead.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      trap       <= 1'b0;
      mret_taken <= 1'b0;
      redirect   <= 1'b0;
      mepc       <= '0;
      mcause     <= '0;
      mtval      <= '0;
    end else begin
      trap       <= take_trap;
      mret_taken <= ret_req & ~take_trap;
      redirect   <= flush;
      if (take_trap) begin
        mepc   <= epc;
        mcause <= next_cause;
        mtval  <= next_tval;
      end
    end
  end

  // Trap entry jumps to the vector, mret returns to mepc.
  assign redirect_pc = trap ? TRAP_VECTOR : mepc;

endmodule

// File: logic/commit_stage.sv
//////////////////////////////////////////////////
// Commit stage
// Turns the committing instruction's flags into
// exception requests, tracks the last valid PC and
// trains the branch predictor.
//////////////////////////////////////////////////
module commit_stage import commit_pkg::*; (
  input  logic  CLK, nRST,
  input  logic  halt, pc_en, intr_pending,
  input  logic  c_valid,
  input  word_t c_pc, c_mem_addr,
  input  logic  c_dren, c_dwen, c_mal_addr,
  input  logic  c_illegal_insn, c_invalid_csr, c_mal_insn,
  input  logic  c_breakpoint, c_ecall, c_ret,
  input  logic  c_jump,
  input  word_t c_jump_addr,
  input  logic  c_branch,
  input  word_t c_br_addr,
  input  logic  c_branch_taken, c_prediction,
  output logic  intr_taken, retire,
  output logic  mal_insn_req, illegal_req, break_req, ecall_req, ret_req,
  output logic  mal_load_req, mal_store_req,
  output word_t bad_addr_i, bad_addr_d, epc,
  output logic  bht_update,
  output word_t bht_addr,
  output logic  bht_taken, mispredict
);

  logic  mis_jump_addr;
  logic  mis_br_addr;
  word_t latest_valid_pc;

  // An interrupt is taken whenever the pipeline moves.
  // It blocks the retire of the instruction sitting in commit.
  assign intr_taken = intr_pending & pc_en;
  assign retire     = c_valid & pc_en & ~intr_pending;

  // Control transfer targets must be word aligned.
  assign mis_jump_addr = c_jump & (c_jump_addr[1:0] != 2'b00);
  assign mis_br_addr   = c_branch & (c_br_addr[1:0] != 2'b00);

  // Exception requests, each valid only for a retiring instruction.
  assign mal_insn_req  = retire & (c_mal_insn | mis_jump_addr | mis_br_addr);
  assign illegal_req   = retire & (c_illegal_insn | c_invalid_csr);
  assign break_req     = retire & c_breakpoint;
  assign ecall_req     = retire & c_ecall;
  assign ret_req       = retire & c_ret;
  assign mal_load_req  = retire & c_dren & c_mal_addr;
  assign mal_store_req = retire & c_dwen & c_mal_addr;

  // Faulting addresses for mtval.
  assign bad_addr_i = c_pc;
  assign bad_addr_d = c_mem_addr;

  // Return address for a trap.
  // Over a bubble the last PC that reached commit is used instead.
  assign epc = c_valid ? c_pc : latest_valid_pc;

  // The last valid PC seen in commit is cleared by halt.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      latest_valid_pc <= '0;
    end else if (halt) begin
      latest_valid_pc <= '0;
    end else if (c_valid && pc_en) begin
      latest_valid_pc <= c_pc;
    end
  end

  // Predictor training on every retired branch.
  assign bht_update = c_branch & retire;
  assign bht_addr   = c_br_addr;
  assign bht_taken  = c_branch_taken;

  // Misprediction pulse in the retire cycle.
  assign mispredict = bht_update & (c_branch_taken != c_prediction);

endmodule

// File: logic/execute_commit_reg.sv
//////////////////////////////////////////////////
// Execute to commit pipeline register
// Holds one finished instruction, stalls on pc_en
// and drops its valid bit on a flush.
//////////////////////////////////////////////////
module execute_commit_reg import commit_pkg::*; (
  input  logic  CLK, nRST,
  input  logic  pc_en, flush,
  input  logic  ex_valid,
  input  word_t ex_pc, ex_mem_addr,
  input  logic  ex_dren, ex_dwen, ex_mal_addr,
  input  logic  ex_illegal_insn, ex_invalid_csr, ex_mal_insn,
  input  logic  ex_breakpoint, ex_ecall, ex_ret,
  input  logic  ex_jump,
  input  word_t ex_jump_addr,
  input  logic  ex_branch,
  input  word_t ex_br_addr,
  input  logic  ex_branch_taken, ex_prediction,
  output logic  c_valid,
  output word_t c_pc, c_mem_addr,
  output logic  c_dren, c_dwen, c_mal_addr,
  output logic  c_illegal_insn, c_invalid_csr, c_mal_insn,
  output logic  c_breakpoint, c_ecall, c_ret,
  output logic  c_jump,
  output word_t c_jump_addr,
  output logic  c_branch,
  output word_t c_br_addr,
  output logic  c_branch_taken, c_prediction
);

  // Valid bit of the committing slot.
  // A flush wins over a capture and acts even during a stall.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      c_valid <= 1'b0;
    end else if (flush) begin
      c_valid <= 1'b0;
    end else if (pc_en) begin
      c_valid <= ex_valid;
    end
  end

  // The instruction payload is captured whenever the pipeline moves.
  always_ff @(posedge CLK) begin
    if (pc_en) begin
      c_pc           <= ex_pc;
      c_mem_addr     <= ex_mem_addr;
      c_dren         <= ex_dren;
      c_dwen         <= ex_dwen;
      c_mal_addr     <= ex_mal_addr;
      c_illegal_insn <= ex_illegal_insn;
      c_invalid_csr  <= ex_invalid_csr;
      c_mal_insn     <= ex_mal_insn;
      c_breakpoint   <= ex_breakpoint;
      c_ecall        <= ex_ecall;
      c_ret          <= ex_ret;
      c_jump         <= ex_jump;
      c_jump_addr    <= ex_jump_addr;
      c_branch       <= ex_branch;
      c_br_addr      <= ex_br_addr;
      c_branch_taken <= ex_branch_taken;
      c_prediction   <= ex_prediction;
    end
  end

endmodule

// File: logic/commit_pkg.sv
//////////////////////////////////////////////////
// Commit package
// Shared widths, exception cause codes, the mcause
// layout and default parameters for the commit end.
//////////////////////////////////////////////////
package commit_pkg;

  // Data and address width of the core.
  localparam int XLEN = 32;

  // PCs, memory addresses and trap register contents.
  typedef logic [XLEN-1:0] word_t;

  // Exception codes as written into the mcause cause field.
  typedef enum logic [30:0] {
    CAUSE_MAL_INSN   = 31'd0,
    CAUSE_ILLEGAL    = 31'd2,
    CAUSE_BREAKPOINT = 31'd3,
    CAUSE_MAL_LOAD   = 31'd4,
    CAUSE_MAL_STORE  = 31'd6,
    CAUSE_ECALL_M    = 31'd11
  } cause_code_t;

  // The external interrupt shares code 11 with ecall from M-mode.
  // The two are told apart by the interrupt flag in mcause.
  localparam cause_code_t CAUSE_EXT_INTR = CAUSE_ECALL_M;

  // mcause is seen as a raw CSR word or as flag plus code.
  typedef union packed {
    word_t raw;
    struct packed {
      logic        interrupt;
      cause_code_t code;
    } f;
  } mcause_t;

  // Fixed trap entry address.
  localparam word_t TRAP_VECTOR_DEFAULT = 32'h0000_0100;

  // Branch history table depth, a power of two.
  localparam int BHT_ENTRIES_DEFAULT = 16;

endpackage
